// ==== Makefile ====
TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := zbuf_tb
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/zbuf_cfg.svh ====
// zbuf configuration: framebuffer size, field widths and fifo depth
`ifndef ZBUF_CFG_SVH
`define ZBUF_CFG_SVH

// framebuffer size in pixels
// kept tiny so a full clear sweep is only 128 cycles
`define ZBUF_HRES 16
`define ZBUF_VRES 8

// log2 of hres * vres
`define ZBUF_ADDR_W 7

// stored depth, zero means empty pixel
`define ZBUF_DEPTH_W 12

// rgb565
`define ZBUF_COLOR_W 16

// entries in each stream fifo
`define ZBUF_FIFO_DEPTH 4

`endif

// ==== common/zbuf_pkg.sv ====
// zbuf shared types: pixel address, depth, colour, fragment and pixel write payloads
`include "zbuf_cfg.svh"

package zbuf_pkg;

  // linear framebuffer address, row major
  typedef logic [`ZBUF_ADDR_W-1:0] addr_t;

  // depth value
  // smaller is closer, zero marks an empty pixel
  typedef logic [`ZBUF_DEPTH_W-1:0] depth_t;

  // rgb565 colour
  // r in [15:11], g in [10:5], b in [4:0]
  typedef logic [`ZBUF_COLOR_W-1:0] color_t;

  // rasterizer output, one per covered pixel
  // 7 + 12 + 16 = 35 bits
  typedef struct packed {
    addr_t  addr;
    depth_t depth;
    color_t color;
  } fragment_t;

  // framebuffer write, produced by a winning fragment or a clear
  // depth is not carried, only the depth buffer needs it
  // 7 + 16 = 23 bits
  typedef struct packed {
    addr_t  addr;
    color_t color;
  } pixel_write_t;

endpackage

// ==== depth_test/depth_ram.sv ====
// depth ram: on-chip depth buffer, registered read-first read port and one write port
`timescale 1ns/1ps
`include "zbuf_cfg.svh"

module depth_ram (
  input  logic             clk_100_passthrough,
  input  logic             rst_n,
  input  logic             rd_en,
  input  zbuf_pkg::addr_t  rd_addr,
  output zbuf_pkg::depth_t rd_depth,
  input  logic             wr_en,
  input  zbuf_pkg::addr_t  wr_addr,
  input  zbuf_pkg::depth_t wr_depth
);

  localparam int WORDS = `ZBUF_HRES * `ZBUF_VRES;

  zbuf_pkg::depth_t mem [WORDS];

  // reset empties every pixel, so the buffer reads zero afterwards
  // same-address read and write return the old depth
  always_ff @(posedge clk_100_passthrough) begin
    if (!rst_n) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
      rd_depth <= '0;
    end else begin
      if (rd_en) begin
        rd_depth <= mem[rd_addr];
      end
      if (wr_en) begin
        mem[wr_addr] <= wr_depth;
      end
    end
  end

endmodule

// ==== depth_test/depth_test_pipe.sv ====
// depth test pipe: two-stage read-compare-write against the depth buffer, credit gated
`timescale 1ns/1ps
`include "zbuf_cfg.svh"

module depth_test_pipe (
  input  logic                                   clk_100_passthrough,
  input  logic                                   rst_n,
  input  logic                                   frag_valid,
  output logic                                   frag_ready,
  input  zbuf_pkg::fragment_t                    frag,
  input  logic                                   clr_valid,
  output logic                                   clr_ready,
  input  zbuf_pkg::addr_t                        clr_addr,
  input  logic [$clog2(`ZBUF_FIFO_DEPTH + 1)-1:0] credit,
  output logic                                   pix_valid,
  output zbuf_pkg::pixel_write_t                 pix
);

  localparam int CREDIT_W = $clog2(`ZBUF_FIFO_DEPTH + 1);

  // issue control
  logic [CREDIT_W-1:0] in_flight;
  logic                issue_ok;
  logic                issue;

  // stage 1: read issued to the ram
  logic                s1_valid;
  logic                s1_clear;
  zbuf_pkg::fragment_t s1_frag;

  // stage 2: compare and write
  logic                s2_valid;
  logic                s2_clear;
  zbuf_pkg::fragment_t s2_frag;
  logic                s2_fwd_hit;
  zbuf_pkg::depth_t    s2_fwd_depth;

  // ram side
  logic                rd_en;
  zbuf_pkg::depth_t    rd_depth;
  zbuf_pkg::depth_t    stored_depth;
  logic                win;
  logic                wr_en;

  // everything in s1/s2 may still land in the output fifo
  assign in_flight = CREDIT_W'(s1_valid) + CREDIT_W'(s2_valid);
  assign issue_ok  = (credit > in_flight);

  // clears take priority while a sweep is pending
  assign clr_ready  = issue_ok;
  assign frag_ready = issue_ok && !clr_valid;
  assign issue      = issue_ok && (clr_valid || frag_valid);

  // clear items need no lookup
  assign rd_en = s1_valid && !s1_clear;

  depth_ram u_depth_ram (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .rd_en               (rd_en),
    .rd_addr             (s1_frag.addr),
    .rd_depth            (rd_depth),
    .wr_en               (wr_en),
    .wr_addr             (s2_frag.addr),
    .wr_depth            (s2_frag.depth)
  );

  // forwarded depth beats the ram output
  // the ram read happened on the same edge as the older write
  assign stored_depth = s2_fwd_hit ? s2_fwd_depth : rd_depth;

  // empty pixel or strictly closer wins, clears always win
  assign win   = s2_clear || (stored_depth == '0) || (s2_frag.depth < stored_depth);
  assign wr_en = s2_valid && win;

  // losers vanish here
  assign pix_valid = wr_en;
  assign pix.addr  = s2_frag.addr;
  assign pix.color = s2_frag.color;

  // valid bits
  always_ff @(posedge clk_100_passthrough) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
      s2_valid <= s1_valid;
    end
  end

  // stage 1 payload
  always_ff @(posedge clk_100_passthrough) begin
    if (issue) begin
      s1_clear <= clr_valid;
      if (clr_valid) begin
        // clear writes depth zero and colour zero
        s1_frag.addr  <= clr_addr;
        s1_frag.depth <= '0;
        s1_frag.color <= '0;
      end else begin
        s1_frag <= frag;
      end
    end
  end

  // stage 2 payload plus forwarding from the write in flight
  always_ff @(posedge clk_100_passthrough) begin
    s2_clear     <= s1_clear;
    s2_frag      <= s1_frag;
    s2_fwd_hit   <= wr_en && (s2_frag.addr == s1_frag.addr);
    s2_fwd_depth <= s2_frag.depth;
  end

endmodule

// ==== list.f ====
+incdir+common
common/zbuf_pkg.sv
logic/stream_fifo.sv
logic/clear_sequencer.sv
depth_test/depth_ram.sv
depth_test/depth_test_pipe.sv
logic/zbuf_top.sv
verification/zbuf_asserts.sv
verification/zbuf_tb.sv

// ==== logic/clear_sequencer.sv ====
// clear sequencer: takes a clear request and streams every framebuffer address in order
`timescale 1ns/1ps
`include "zbuf_cfg.svh"

module clear_sequencer (
  input  logic            clk_100_passthrough,
  input  logic            rst_n,
  input  logic            clear_req,
  output logic            clear_ack,
  output logic            clear_busy,
  output logic            addr_valid,
  input  logic            addr_ready,
  output zbuf_pkg::addr_t addr
);

  localparam zbuf_pkg::addr_t LAST_ADDR = zbuf_pkg::addr_t'(`ZBUF_HRES * `ZBUF_VRES - 1);

  typedef enum logic {
    SEQ_IDLE,
    SEQ_SWEEP
  } seq_state_t;

  seq_state_t state;

  // only accept a new clear once the previous sweep has fully issued
  assign clear_ack  = (state == SEQ_IDLE) && clear_req;
  assign clear_busy = (state == SEQ_SWEEP);

  // one address per cycle while sweeping
  assign addr_valid = (state == SEQ_SWEEP);

  always_ff @(posedge clk_100_passthrough) begin
    if (!rst_n) begin
      state <= SEQ_IDLE;
      addr  <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (clear_ack) begin
            state <= SEQ_SWEEP;
            addr  <= '0;
          end
        end
        SEQ_SWEEP: begin
          if (addr_ready) begin
            // stop after the last pixel
            if (addr == LAST_ADDR) begin
              state <= SEQ_IDLE;
            end else begin
              addr <= addr + 1'b1;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/stream_fifo.sv ====
// stream fifo: valid/ready circular buffer for any payload type, reports free slots
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic                         clk_100_passthrough,
  input  logic                         rst_n,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  payload_t                     in_data,
  output logic                         out_valid,
  input  logic                         out_ready,
  output payload_t                     out_data,
  output logic [$clog2(DEPTH + 1)-1:0] free_slots
);

  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  // storage, no reset needed
  payload_t mem [DEPTH];

  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [COUNT_W-1:0] count;
  logic               push;
  logic               pop;

  // full / empty straight from the count
  assign in_ready  = (count != COUNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  // seen from the write side
  assign free_slots = COUNT_W'(DEPTH) - count;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk_100_passthrough) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk_100_passthrough) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at DEPTH, not only at powers of two
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== logic/zbuf_top.sv ====
// zbuf top: fragment fifo and clear sequencer feed the depth test, winners leave via a fifo
`timescale 1ns/1ps
`include "zbuf_cfg.svh"

module zbuf_top (
  input  logic                   clk_100_passthrough,
  input  logic                   rst_n,
  input  logic                   frag_valid,
  output logic                   frag_ready,
  input  zbuf_pkg::fragment_t    frag_data,
  input  logic                   clear_req,
  output logic                   clear_ack,
  output logic                   clear_busy,
  output logic                   pix_valid,
  input  logic                   pix_ready,
  output zbuf_pkg::pixel_write_t pix_data
);

  // input fifo to pipe
  logic                  fifo_frag_valid;
  logic                  fifo_frag_ready;
  zbuf_pkg::fragment_t   fifo_frag;

  // sequencer to pipe
  logic                  seq_addr_valid;
  logic                  seq_addr_ready;
  zbuf_pkg::addr_t       seq_addr;

  // pipe to output fifo, credit back
  logic                  pipe_pix_valid;
  zbuf_pkg::pixel_write_t pipe_pix;
  logic [$clog2(`ZBUF_FIFO_DEPTH + 1)-1:0] pix_credit;

  stream_fifo #(
    .payload_t (zbuf_pkg::fragment_t),
    .DEPTH     (`ZBUF_FIFO_DEPTH)
  ) u_frag_fifo (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .in_valid            (frag_valid),
    .in_ready            (frag_ready),
    .in_data             (frag_data),
    .out_valid           (fifo_frag_valid),
    .out_ready           (fifo_frag_ready),
    .out_data            (fifo_frag),
    .free_slots          ()
  );

  clear_sequencer u_clear_seq (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .clear_req           (clear_req),
    .clear_ack           (clear_ack),
    .clear_busy          (clear_busy),
    .addr_valid          (seq_addr_valid),
    .addr_ready          (seq_addr_ready),
    .addr                (seq_addr)
  );

  depth_test_pipe u_depth_test (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .frag_valid          (fifo_frag_valid),
    .frag_ready          (fifo_frag_ready),
    .frag                (fifo_frag),
    .clr_valid           (seq_addr_valid),
    .clr_ready           (seq_addr_ready),
    .clr_addr            (seq_addr),
    .credit              (pix_credit),
    .pix_valid           (pipe_pix_valid),
    .pix                 (pipe_pix)
  );

  // credit keeps this fifo from overflowing, so its in_ready is not needed
  stream_fifo #(
    .payload_t (zbuf_pkg::pixel_write_t),
    .DEPTH     (`ZBUF_FIFO_DEPTH)
  ) u_pix_fifo (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .in_valid            (pipe_pix_valid),
    .in_ready            (),
    .in_data             (pipe_pix),
    .out_valid           (pix_valid),
    .out_ready           (pix_ready),
    .out_data            (pix_data),
    .free_slots          (pix_credit)
  );

endmodule

// ==== verification/zbuf_asserts.sv ====
// zbuf assertions: output stream stability, quiet controls in reset, clear handshake rule
`timescale 1ns/1ps

module zbuf_asserts (
  input logic                   clk_100_passthrough,
  input logic                   rst_n,
  input logic                   clear_ack,
  input logic                   clear_busy,
  input logic                   pix_valid,
  input logic                   pix_ready,
  input zbuf_pkg::pixel_write_t pix_data
);

  // a stalled pixel write keeps valid and payload
  pix_hold: assert property (@(posedge clk_100_passthrough) disable iff (!rst_n)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
    else $error("pixel write dropped or changed while stalled");

  // registers settle on the first reset edge
  reset_quiet: assert property (@(posedge clk_100_passthrough)
    !rst_n && $past(!rst_n) |-> !pix_valid && !clear_ack && !clear_busy)
    else $error("control output active during reset");

  // no new clear while a sweep is issuing
  // an accepted clear starts its sweep on the next cycle
  ack_when_idle: assert property (@(posedge clk_100_passthrough) disable iff (!rst_n)
    clear_ack |-> !clear_busy ##1 clear_busy)
    else $error("clear accepted while sequencer busy or sweep did not start");

endmodule

bind zbuf_top zbuf_asserts u_zbuf_asserts (.*);

// ==== verification/zbuf_tb.sv ====
// zbuf testbench: replays fragments and clears from the data file and checks every pixel write
`timescale 1ns/1ps
`include "zbuf_cfg.svh"

module zbuf_tb;

  localparam int SWEEP_LEN = `ZBUF_HRES * `ZBUF_VRES;

  // one input item: fragment, clear or idle gap
  typedef struct packed {
    logic [7:0]          kind;
    zbuf_pkg::fragment_t frag;
    logic [31:0]         arg;
  } stim_t;

  logic                   clk_100_passthrough = 1'b0;
  logic                   rst_n;
  logic                   frag_valid;
  logic                   frag_ready;
  zbuf_pkg::fragment_t    frag_data;
  logic                   clear_req;
  logic                   clear_ack;
  logic                   clear_busy;
  logic                   pix_valid;
  logic                   pix_ready = 1'b0;
  zbuf_pkg::pixel_write_t pix_data;

  stim_t                  stim_q[$];
  zbuf_pkg::pixel_write_t exp_q[$];
  string                  exp_name_q[$];
  zbuf_pkg::pixel_write_t want;
  string                  want_name;
  int                     got_count = 0;
  int                     limit_cycles = 0;

  // 8 ns period
  always #4 clk_100_passthrough = ~clk_100_passthrough;

  zbuf_top dut (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .frag_valid          (frag_valid),
    .frag_ready          (frag_ready),
    .frag_data           (frag_data),
    .clear_req           (clear_req),
    .clear_ack           (clear_ack),
    .clear_busy          (clear_busy),
    .pix_valid           (pix_valid),
    .pix_ready           (pix_ready),
    .pix_data            (pix_data)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flag(input string test, input logic expected, input logic actual);
    assert (expected == actual) else begin
      fail_run($sformatf("ERROR %s: expected %b actual %b", test, expected, actual));
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          n;
    int          lines;
    string       line;
    string       test;
    logic [7:0]  kind;
    int unsigned a;
    int unsigned b;
    int unsigned c;
    stim_t       item;
    fd = $fopen("verification/zbuf_testdata.txt", "r");
    if (fd == 0) begin
      fail_run("could not open verification/zbuf_testdata.txt");
    end else begin
      lines = 0;
      test = "none";
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // blank lines and comments carry nothing
        if (n > 1 && line.getc(0) != "#") begin
          lines++;
          kind = line.getc(0);
          a = 0;
          b = 0;
          c = 0;
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
          item = '0;
          item.kind = kind;
          case (kind)
            "T": n = $sscanf(line, "T %s", test);
            "F", "B": begin
              item.frag.addr  = zbuf_pkg::addr_t'(a);
              item.frag.depth = zbuf_pkg::depth_t'(b);
              item.frag.color = zbuf_pkg::color_t'(c);
              stim_q.push_back(item);
            end
            "W": begin
              item.arg = a;
              stim_q.push_back(item);
            end
            "C": begin
              // the clear waits until everything listed before it has come out
              item.arg = exp_q.size();
              stim_q.push_back(item);
              // sweep: every address in ascending order, colour zero
              for (int i = 0; i < SWEEP_LEN; i++) begin
                exp_q.push_back({zbuf_pkg::addr_t'(i), zbuf_pkg::color_t'(0)});
                exp_name_q.push_back(test);
              end
            end
            "E": begin
              // address then colour
              exp_q.push_back({zbuf_pkg::addr_t'(a), zbuf_pkg::color_t'(b)});
              exp_name_q.push_back(test);
            end
            default: fail_run($sformatf("unknown line in data file: %s", line));
          endcase
        end
      end
      $fclose(fd);
      limit_cycles = (lines + 1) * 200;
    end
  endtask

  // caller sits on a falling edge
  task automatic send_fragment(input zbuf_pkg::fragment_t f);
    frag_valid = 1'b1;
    frag_data  = f;
    @(posedge clk_100_passthrough);
    while (!frag_ready) @(posedge clk_100_passthrough);
    @(negedge clk_100_passthrough);
    frag_valid = 1'b0;
  endtask

  task automatic send_clear();
    clear_req = 1'b1;
    @(posedge clk_100_passthrough);
    while (!clear_ack) @(posedge clk_100_passthrough);
    @(negedge clk_100_passthrough);
    clear_req = 1'b0;
  endtask

  // random stalls on the output, about one cycle in four
  always @(negedge clk_100_passthrough) begin
    pix_ready = ($urandom % 4) != 0;
  end

  // compare each transfer with the head of the expected list
  always @(posedge clk_100_passthrough) begin
    if (rst_n && pix_valid && pix_ready) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("unexpected extra pixel write to address %h", pix_data.addr));
      end else begin
        want = exp_q.pop_front();
        want_name = exp_name_q.pop_front();
        got_count++;
        assert (pix_data == want) else begin
          fail_run($sformatf("ERROR %s: expected addr %h colour %h, actual addr %h colour %h",
                             want_name, want.addr, want.color, pix_data.addr, pix_data.color));
        end
      end
    end
  end

  // watchdog, 200 cycles per data line
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_100_passthrough);
    fail_run($sformatf("timeout: no end of run within %0d cycles", limit_cycles));
  end

  initial begin
    stim_t item;
    void'($urandom(32'hc86b_3d4a));
    rst_n      = 1'b0;
    frag_valid = 1'b0;
    frag_data  = '0;
    clear_req  = 1'b0;
    load_testdata();
    repeat (16) @(posedge clk_100_passthrough);
    @(negedge clk_100_passthrough);
    rst_n = 1'b1;
    @(negedge clk_100_passthrough);
    // idle outputs straight after reset
    check_flag("after_reset pix_valid", 1'b0, pix_valid);
    check_flag("after_reset clear_busy", 1'b0, clear_busy);
    check_flag("after_reset frag_ready", 1'b1, frag_ready);
    while (stim_q.size() != 0) begin
      item = stim_q.pop_front();
      case (item.kind)
        "F": begin
          repeat ($urandom % 3) @(negedge clk_100_passthrough);
          send_fragment(item.frag);
        end
        // no gap, follows the previous fragment directly
        "B": send_fragment(item.frag);
        "W": repeat (item.arg) @(negedge clk_100_passthrough);
        "C": begin
          while (got_count < item.arg) @(negedge clk_100_passthrough);
          send_clear();
        end
        default: ;
      endcase
    end
    // every expected write has to come out before the watchdog fires
    while (exp_q.size() != 0) @(negedge clk_100_passthrough);
    // room for any stray write to show up
    repeat (20) @(negedge clk_100_passthrough);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== verification/zbuf_testdata.txt ====
# kind then hex fields: T name | F addr depth colour | B same, no gap | W idle cycles
# E addr colour = expected pixel write, in output order | C = clear, sweep of all addresses
T empty_pixel
F 05 100 f800
E 05 f800
F 06 200 07e0
E 06 07e0
T depth_spaced
F 05 180 001f
W 20
F 05 080 ffff
E 05 ffff
T depth_back_to_back
F 10 300 1234
B 10 300 4321
B 10 2ff abcd
B 10 2fe 0f0f
E 10 1234
E 10 abcd
E 10 0f0f
T order_before_clear
F 7f 010 aaaa
E 7f aaaa
T clear_sweep
C
T after_clear
F 05 fff 5555
E 05 5555
F 05 ffe 6666
E 05 6666
B 05 ffe 7777
F 7f 001 0001
E 7f 0001
T order_after_clear
C
F 00 123 beef
B 00 124 dead
E 00 beef
